/* filelist.f */
design/mancala_pkg.sv
design/button_edge.sv
design/pocket_cursor.sv
design/board_sower.sv
design/turn_control.sv
design/mancala_top.sv
dv/tb_clock.sv
dv/mancala_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module mancala_tb -f filelist.f -o mancala_sim

if ! ./obj_dir/mancala_sim > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
exit 0

/* dv/mancala_tb.sv */
`timescale 1ns/100ps

module mancala_tb
    import mancala_pkg::*;
();

    localparam int SEEDS       = 4;
    localparam int SYNC        = 2;
    localparam int TOTAL_SEEDS = 2 * PITS_PER_SIDE * SEEDS;
    localparam int PERIOD_NS   = 20;
    // level held long enough for the synchronizer and the cursor update
    localparam int HOLD_CYCLES = SYNC + 2;
    localparam int MOVE_LIMIT  = 120;
    localparam int MOVE_CYCLES = 80;
    // every move of a long game plus the directed tests, about 200 us
    localparam int BUDGET_NS   = (MOVE_LIMIT * MOVE_CYCLES + 400) * PERIOD_NS;

    localparam buttons_t PRESS_LEFT  = '{left: 1'b1, right: 1'b0, enter: 1'b0};
    localparam buttons_t PRESS_RIGHT = '{left: 1'b0, right: 1'b1, enter: 1'b0};
    localparam buttons_t PRESS_ENTER = '{left: 1'b0, right: 1'b0, enter: 1'b1};

    logic       clk_1;
    logic       rst;
    buttons_t   btn_levels;
    board_t     board;
    player_t    turn;
    place_idx_t cursor;
    phase_t     phase;
    result_t    result;
    logic       move_done;

    int         errors;
    int         model_pl [NUM_PLACES];
    player_t    model_turn;
    sow_end_t   model_end;

    tb_clock #(
        .PERIOD_NS    (PERIOD_NS),
        .RESET_CYCLES (5)
    ) u_clock (
        .clk_1 (clk_1),
        .rst   (rst)
    );

    mancala_top #(
        .SEEDS_PER_PIT (SEEDS),
        .SYNC_STAGES   (SYNC)
    ) u_dut (
        .clk_1      (clk_1),
        .rst        (rst),
        .btn_levels (btn_levels),
        .board      (board),
        .turn       (turn),
        .cursor     (cursor),
        .phase      (phase),
        .result     (result),
        .move_done  (move_done)
    );

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_board(input board_t got, input board_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s, board %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_player(input player_t got, input player_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s, turn %s expected %s", $time, what, got.name(), exp.name());
        end
    endtask

    task automatic check_place(input place_idx_t got, input place_idx_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s, place %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_phase(input phase_t got, input phase_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s, phase %s expected %s", $time, what, got.name(), exp.name());
        end
    endtask

    task automatic check_result(input result_t got, input result_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s, result %s expected %s", $time, what, got.name(), exp.name());
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s, level %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_total(input int got, input int exp, input string what);
        if (got != exp) begin
            errors++;
            $display("FAIL %0t: %s, seed total %0d expected %0d", $time, what, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // board model
    ////////////////////////////////////////////////////////////////////////////

    function automatic board_t model_board();
        place_arr_t flat;
        for (int i = 0; i < NUM_PLACES; i++) begin
            flat[i] = seed_cnt_t'(model_pl[i]);
        end
        return board_t'(flat);
    endfunction

    function automatic int board_sum(input board_t b);
        place_arr_t flat;
        int         sum;
        flat = place_arr_t'(b);
        sum  = 0;
        for (int i = 0; i < NUM_PLACES; i++) begin
            sum += int'(flat[i]);
        end
        return sum;
    endfunction

    function automatic int model_row(input player_t who);
        int sum;
        int first;
        sum   = 0;
        first = (who == PLAYER_A) ? 0 : 7;
        for (int i = first; i < first + PITS_PER_SIDE; i++) begin
            sum += model_pl[i];
        end
        return sum;
    endfunction

    // the opponent's store is skipped
    function automatic int step_place(input int p, input player_t who);
        int skip;
        int n;
        skip = (who == PLAYER_A) ? 13 : 6;
        n    = (p + 1) % NUM_PLACES;
        if (n == skip) n = (n + 1) % NUM_PLACES;
        return n;
    endfunction

    task automatic model_reset();
        for (int i = 0; i < NUM_PLACES; i++) begin
            model_pl[i] = (i == 6 || i == 13) ? 0 : SEEDS;
        end
        model_turn = PLAYER_A;
    endtask

    task automatic model_move(input int pocket);
        int hand;
        int pos;
        int own;
        int sown;
        own       = (model_turn == PLAYER_A) ? 6 : 13;
        hand      = model_pl[pocket];
        model_pl[pocket] = 0;
        pos       = pocket;
        sown      = 0;
        model_end = END_NONE;
        while (model_end == END_NONE && sown < 5000) begin
            pos = step_place(pos, model_turn);
            model_pl[pos]++;
            hand--;
            sown++;
            if (hand == 0) begin
                if (pos == own) begin
                    model_end = END_STORE;
                end else if (model_pl[pos] == 1) begin
                    model_end  = END_EMPTY;
                    model_turn = (model_turn == PLAYER_A) ? PLAYER_B : PLAYER_A;
                end else begin
                    // relay picks up the pocket with the seed that landed
                    hand          = model_pl[pos];
                    model_pl[pos] = 0;
                end
            end
        end
        if (model_end == END_NONE) begin
            errors++;
            $display("board model found a move that never ends at pocket %0d", pocket);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic tap(input buttons_t which);
        btn_levels = which;
        repeat (HOLD_CYCLES) @(negedge clk_1);
        btn_levels = '0;
        repeat (HOLD_CYCLES) @(negedge clk_1);
    endtask

    task automatic move_cursor(input place_idx_t target);
        int steps;
        steps = 0;
        while (cursor != target && steps < 12) begin
            // right walks up for A and down for B
            if ((turn == PLAYER_A) == (cursor < target)) tap(PRESS_RIGHT);
            else tap(PRESS_LEFT);
            steps++;
        end
        check_place(cursor, target, "cursor on the chosen pocket");
    endtask

    task automatic play_pocket(input place_idx_t pocket, input string what);
        move_cursor(pocket);
        model_move(int'(pocket));
        btn_levels = PRESS_ENTER;
        while (!move_done) @(negedge clk_1);
        btn_levels = '0;
        // turn settles one cycle after move_done, the sweep comes later
        @(negedge clk_1);
        check_level(move_done, 1'b0, "move_done pulse over");
        check_board(board, model_board(), what);
        check_player(turn, model_turn, what);
        check_phase(phase, PH_SELECT, what);
        check_total(board_sum(board), TOTAL_SEEDS, what);
        repeat (HOLD_CYCLES) @(negedge clk_1);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        while (phase != PH_SELECT) @(negedge clk_1);
        check_board(board, model_board(), "reset board");
        check_player(turn, PLAYER_A, "reset turn");
        check_place(cursor, 4'd0, "reset cursor");
        check_result(result, RES_NONE, "reset result");
    endtask

    task automatic test_cursor_a();
        repeat (5) tap(PRESS_RIGHT);
        check_place(cursor, 4'd5, "A cursor at right end");
        repeat (2) tap(PRESS_RIGHT);
        check_place(cursor, 4'd5, "A cursor held at 5");
        repeat (7) tap(PRESS_LEFT);
        check_place(cursor, 4'd0, "A cursor held at 0");
    endtask

    task automatic test_extra_turn();
        play_pocket(4'd2, "move ending in A's store");
        check_player(turn, PLAYER_A, "A moves again");
        check_place(cursor, 4'd0, "cursor back home for A");
    endtask

    task automatic test_empty_pocket();
        move_cursor(4'd2);
        tap(PRESS_ENTER);
        check_phase(phase, PH_SELECT, "enter on empty pocket");
        check_board(board, model_board(), "enter on empty pocket");
        check_player(turn, PLAYER_A, "enter on empty pocket");
    endtask

    task automatic test_relay();
        play_pocket(4'd0, "relay move");
    endtask

    task automatic test_cursor_b();
        check_place(cursor, 4'd12, "B cursor starts at 12");
        repeat (2) tap(PRESS_LEFT);
        check_place(cursor, 4'd12, "B cursor held at 12");
        repeat (7) tap(PRESS_RIGHT);
        check_place(cursor, 4'd7, "B cursor held at 7");
        repeat (7) tap(PRESS_LEFT);
        check_place(cursor, 4'd12, "B cursor back at 12");
    endtask

    task automatic test_random_game();
        int moves;
        int count;
        int first;
        int pick;
        int choices [PITS_PER_SIDE];
        moves = 0;
        while (model_row(model_turn) != 0 && moves < MOVE_LIMIT) begin
            first = (model_turn == PLAYER_A) ? 0 : 7;
            count = 0;
            for (int i = first; i < first + PITS_PER_SIDE; i++) begin
                if (model_pl[i] != 0) begin
                    choices[count] = i;
                    count++;
                end
            end
            pick = $urandom_range(count - 1, 0);
            play_pocket(place_idx_t'(choices[pick]), "random move");
            moves++;
        end
        if (model_row(model_turn) != 0) begin
            errors++;
            $display("random game still running after %0d moves", MOVE_LIMIT);
        end
        while (phase != PH_OVER) @(negedge clk_1);
    endtask

    task automatic test_end_game();
        result_t exp_result;
        model_pl[6]  += model_row(PLAYER_A);
        model_pl[13] += model_row(PLAYER_B);
        for (int i = 0; i < PITS_PER_SIDE; i++) begin
            model_pl[i]     = 0;
            model_pl[i + 7] = 0;
        end
        if (model_pl[6] > model_pl[13]) exp_result = RES_A_WINS;
        else if (model_pl[13] > model_pl[6]) exp_result = RES_B_WINS;
        else exp_result = RES_TIE;
        check_phase(phase, PH_OVER, "game over");
        check_board(board, model_board(), "board after sweep");
        check_result(result, exp_result, "winner");
        check_total(board_sum(board), TOTAL_SEEDS, "after sweep");
        // buttons are dead once the game is over
        tap(PRESS_ENTER);
        check_board(board, model_board(), "enter after game over");
        check_phase(phase, PH_OVER, "enter after game over");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        btn_levels = '0;
        errors     = 0;
        void'($urandom(32'hb4d0));
        model_reset();
        while (rst) @(negedge clk_1);
        test_reset_state();
        test_cursor_a();
        test_extra_turn();
        test_empty_pocket();
        test_relay();
        test_cursor_b();
        test_random_game();
        test_end_game();
        $display("tests finished with %0d errors", errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(BUDGET_NS);
        $display("watchdog expired before the tests finished, %0d errors so far", errors);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* dv/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_1,
    output logic rst
);

    initial begin
        clk_1 = 1'b0;
        forever #(PERIOD_NS / 2) clk_1 = ~clk_1;
    end

    // release away from the rising edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_1);
        @(negedge clk_1);
        rst = 1'b0;
    end

endmodule

/* design/mancala_top.sv */
`timescale 1ns/100ps

module mancala_top
    import mancala_pkg::*;
#(
    parameter int SEEDS_PER_PIT = 4,
    parameter int SYNC_STAGES   = 2
) (
    input  logic       clk_1,
    input  logic       rst,
    input  buttons_t   btn_levels,
    output board_t     board,
    output player_t    turn,
    output place_idx_t cursor,
    output phase_t     phase,
    output result_t    result,
    output logic       move_done
);

    buttons_t   press;
    logic       start_move;
    place_idx_t sel_pocket;
    logic       start_sweep;
    sow_end_t   sow_end;
    logic       row_a_empty;
    logic       row_b_empty;

    button_edge #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_button_edge (
        .clk_1      (clk_1),
        .rst        (rst),
        .btn_levels (btn_levels),
        .press      (press)
    );

    pocket_cursor u_pocket_cursor (
        .clk_1  (clk_1),
        .rst    (rst),
        .press  (press),
        .phase  (phase),
        .turn   (turn),
        .cursor (cursor)
    );

    board_sower #(
        .SEEDS_PER_PIT (SEEDS_PER_PIT)
    ) u_board_sower (
        .clk_1       (clk_1),
        .rst         (rst),
        .phase       (phase),
        .turn        (turn),
        .start_move  (start_move),
        .sel_pocket  (sel_pocket),
        .start_sweep (start_sweep),
        .board       (board),
        .sow_end     (sow_end),
        .row_a_empty (row_a_empty),
        .row_b_empty (row_b_empty)
    );

    turn_control #(
        .SEEDS_PER_PIT (SEEDS_PER_PIT)
    ) u_turn_control (
        .clk_1       (clk_1),
        .rst         (rst),
        .press       (press),
        .cursor      (cursor),
        .board       (board),
        .sow_end     (sow_end),
        .row_a_empty (row_a_empty),
        .row_b_empty (row_b_empty),
        .phase       (phase),
        .turn        (turn),
        .start_move  (start_move),
        .sel_pocket  (sel_pocket),
        .start_sweep (start_sweep),
        .move_done   (move_done),
        .result      (result)
    );

endmodule

/* design/turn_control.sv */
`timescale 1ns/100ps

module turn_control
    import mancala_pkg::*;
#(
    parameter int SEEDS_PER_PIT = 4
) (
    input  logic       clk_1,
    input  logic       rst,
    input  buttons_t   press,
    input  place_idx_t cursor,
    input  board_t     board,
    input  sow_end_t   sow_end,
    input  logic       row_a_empty,
    input  logic       row_b_empty,
    output phase_t     phase,
    output player_t    turn,
    output logic       start_move,
    output place_idx_t sel_pocket,
    output logic       start_sweep,
    output logic       move_done,
    output result_t    result
);

    logic      active_empty;
    // store totals as they will be once the sweep lands
    seed_cnt_t final_a;
    seed_cnt_t final_b;

    assign active_empty = (turn == PLAYER_A) ? row_a_empty : row_b_empty;
    assign sel_pocket   = cursor;

    // an empty pocket or a finished row ignores enter
    assign start_move = (phase == PH_SELECT) && !active_empty && press.enter &&
                        (seeds_at(board, cursor) != '0);

    assign start_sweep = (phase == PH_SWEEP);
    assign move_done   = (phase == PH_SOW) && (sow_end != END_NONE);

    assign final_a = board.store_a + row_total(board, PLAYER_A);
    assign final_b = board.store_b + row_total(board, PLAYER_B);

    ////////////////////////////////////////////////////////////////////////////
    // phase machine
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_1 or posedge rst) begin
        if (rst) begin
            phase  <= PH_INIT;
            turn   <= PLAYER_A;
            result <= RES_NONE;
        end else begin
            case (phase)
                PH_INIT: begin
                    phase  <= PH_SELECT;
                    turn   <= PLAYER_A;
                    result <= RES_NONE;
                end
                PH_SELECT: begin
                    // game over as soon as the mover has nothing to pick
                    if (active_empty) begin
                        phase <= PH_SWEEP;
                    end else if (start_move) begin
                        phase <= PH_SOW;
                    end
                end
                PH_SOW: begin
                    if (sow_end != END_NONE) begin
                        phase <= PH_SELECT;
                        // END_STORE keeps the same player for another pick
                        if (sow_end == END_EMPTY) begin
                            turn <= (turn == PLAYER_A) ? PLAYER_B : PLAYER_A;
                        end
                    end
                end
                PH_SWEEP: begin
                    phase <= PH_OVER;
                    if (final_a > final_b) begin
                        result <= RES_A_WINS;
                    end else if (final_b > final_a) begin
                        result <= RES_B_WINS;
                    end else begin
                        result <= RES_TIE;
                    end
                end
                PH_OVER: begin
                    phase <= PH_OVER;
                end
                default: begin
                    phase <= PH_INIT;
                end
            endcase
        end
    end

    // sower must only finish moves that this machine started
    a_move_done_in_sow: assert property (@(posedge clk_1) disable iff (rst)
        (sow_end != END_NONE) |-> (phase == PH_SOW))
        else $error("move end seen outside PH_SOW");

    // after the sweep both stores together hold every seed
    a_stores_hold_all: assert property (@(posedge clk_1) disable iff (rst)
        (phase == PH_OVER) |->
            (int'(board.store_a) + int'(board.store_b) ==
             2 * PITS_PER_SIDE * SEEDS_PER_PIT))
        else $error("stores do not hold all seeds at game over");

endmodule

/* design/board_sower.sv */
`timescale 1ns/100ps

module board_sower
    import mancala_pkg::*;
#(
    parameter int SEEDS_PER_PIT = 4
) (
    input  logic       clk_1,
    input  logic       rst,
    input  phase_t     phase,
    input  player_t    turn,
    input  logic       start_move,
    input  place_idx_t sel_pocket,
    input  logic       start_sweep,
    output board_t     board,
    output sow_end_t   sow_end,
    output logic       row_a_empty,
    output logic       row_b_empty
);

    place_arr_t places_q;
    seed_cnt_t  handful_q;
    // next place to receive a seed
    place_idx_t pos_q;
    logic       sowing_q;
    // last seed hit a full pocket, pick it up on the next cycle
    logic       relay_q;

    place_idx_t own_store;
    seed_cnt_t  sum_a;
    seed_cnt_t  sum_b;
    seed_cnt_t  board_total;

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    // wraps 13 -> 0 and hops over the opponent's store
    function automatic place_idx_t next_place(place_idx_t p, player_t who);
        place_idx_t n;
        n = (p == STORE_B) ? 4'd0 : p + 4'd1;
        if (who == PLAYER_A && n == STORE_B) begin
            n = 4'd0;
        end
        if (who == PLAYER_B && n == STORE_A) begin
            n = STORE_A + 4'd1;
        end
        return n;
    endfunction

    function automatic place_arr_t initial_board();
        place_arr_t b;
        for (int i = 0; i < NUM_PLACES; i++) begin
            if (i == int'(STORE_A) || i == int'(STORE_B)) begin
                b[i] = '0;
            end else begin
                b[i] = seed_cnt_t'(SEEDS_PER_PIT);
            end
        end
        return b;
    endfunction

    assign board       = board_t'(places_q);
    assign own_store   = (turn == PLAYER_A) ? STORE_A : STORE_B;
    assign sum_a       = row_total(board, PLAYER_A);
    assign sum_b       = row_total(board, PLAYER_B);
    assign row_a_empty = (sum_a == '0);
    assign row_b_empty = (sum_b == '0);

    ////////////////////////////////////////////////////////////////////////////
    // pickup, sowing, relay and sweep
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_1 or posedge rst) begin
        if (rst) begin
            places_q  <= initial_board();
            handful_q <= '0;
            pos_q     <= '0;
            sowing_q  <= 1'b0;
            relay_q   <= 1'b0;
            sow_end   <= END_NONE;
        end else begin
            sow_end <= END_NONE;
            if (phase == PH_INIT) begin
                places_q  <= initial_board();
                handful_q <= '0;
                sowing_q  <= 1'b0;
                relay_q   <= 1'b0;
            end else if (start_move) begin
                handful_q             <= places_q[sel_pocket];
                places_q[sel_pocket]  <= '0;
                pos_q                 <= next_place(sel_pocket, turn);
                sowing_q              <= 1'b1;
            end else if (relay_q) begin
                // takes the seed that just landed as well
                handful_q        <= places_q[pos_q];
                places_q[pos_q]  <= '0;
                pos_q            <= next_place(pos_q, turn);
                relay_q          <= 1'b0;
            end else if (sowing_q) begin
                places_q[pos_q] <= places_q[pos_q] + 6'd1;
                handful_q       <= handful_q - 6'd1;
                if (handful_q != 6'd1) begin
                    pos_q <= next_place(pos_q, turn);
                end else if (pos_q == own_store) begin
                    sowing_q <= 1'b0;
                    sow_end  <= END_STORE;
                end else if (places_q[pos_q] == '0) begin
                    sowing_q <= 1'b0;
                    sow_end  <= END_EMPTY;
                end else begin
                    relay_q <= 1'b1;
                end
            end else if (start_sweep) begin
                for (int i = 0; i < PITS_PER_SIDE; i++) begin
                    places_q[i]                    <= '0;
                    places_q[i + int'(STORE_A) + 1] <= '0;
                end
                places_q[STORE_A] <= places_q[STORE_A] + sum_a;
                places_q[STORE_B] <= places_q[STORE_B] + sum_b;
            end
        end
    end

    // seeds are only moved, never made or lost
    assign board_total = sum_a + sum_b + places_q[STORE_A] + places_q[STORE_B] + handful_q;

    a_seeds_conserved: assert property (@(posedge clk_1) disable iff (rst)
        board_total == seed_cnt_t'(2 * PITS_PER_SIDE * SEEDS_PER_PIT))
        else $error("seed total changed");

    a_no_start_while_sowing: assert property (@(posedge clk_1) disable iff (rst)
        start_move |-> !sowing_q)
        else $error("start_move while a move is still sowing");

endmodule

/* design/pocket_cursor.sv */
`timescale 1ns/100ps

module pocket_cursor
    import mancala_pkg::*;
(
    input  logic       clk_1,
    input  logic       rst,
    input  buttons_t   press,
    input  phase_t     phase,
    input  player_t    turn,
    output place_idx_t cursor
);

    localparam place_idx_t A_FIRST = 4'd0;
    localparam place_idx_t A_LAST  = STORE_A - 4'd1;
    localparam place_idx_t B_FIRST = STORE_A + 4'd1;
    localparam place_idx_t B_LAST  = STORE_B - 4'd1;

    place_idx_t pos_q;
    // set outside selection, so a new turn starts at its home pocket
    logic       fresh_q;
    place_idx_t start_pocket;
    place_idx_t next_pos;

    assign start_pocket = (turn == PLAYER_A) ? A_FIRST : B_LAST;

    // home pocket shows in the very first select cycle, before any press
    assign cursor = (fresh_q && phase == PH_SELECT) ? start_pocket : pos_q;

    // B sits mirrored, so left walks up the indices for B
    always_comb begin
        next_pos = cursor;
        if (turn == PLAYER_A) begin
            if (press.left) begin
                if (cursor != A_FIRST) next_pos = cursor - 4'd1;
            end else if (press.right) begin
                if (cursor != A_LAST) next_pos = cursor + 4'd1;
            end
        end else begin
            if (press.left) begin
                if (cursor != B_LAST) next_pos = cursor + 4'd1;
            end else if (press.right) begin
                if (cursor != B_FIRST) next_pos = cursor - 4'd1;
            end
        end
    end

    always_ff @(posedge clk_1 or posedge rst) begin
        if (rst) begin
            pos_q   <= A_FIRST;
            fresh_q <= 1'b1;
        end else if (phase == PH_SELECT) begin
            pos_q   <= next_pos;
            fresh_q <= 1'b0;
        end else begin
            fresh_q <= 1'b1;
        end
    end

    // turn comes from turn_control, so this ties both sides together
    a_cursor_in_row: assert property (@(posedge clk_1) disable iff (rst)
        (phase == PH_SELECT) |->
            ((turn == PLAYER_A) ? (cursor <= A_LAST)
                                : (cursor >= B_FIRST && cursor <= B_LAST)))
        else $error("cursor outside the active row");

endmodule

/* design/button_edge.sv */
`timescale 1ns/100ps

module button_edge
    import mancala_pkg::*;
#(
    parameter int SYNC_STAGES = 2
) (
    input  logic     clk_1,
    input  logic     rst,
    input  buttons_t btn_levels,
    output buttons_t press
);

    // stages 0..SYNC_STAGES-1 synchronize, the last one holds the old level
    buttons_t [SYNC_STAGES:0] sync_q;
    buttons_t                 rise;

    // high only on the first synced cycle of a press
    assign rise = buttons_t'(sync_q[SYNC_STAGES-1] & ~sync_q[SYNC_STAGES]);

    always_ff @(posedge clk_1 or posedge rst) begin
        if (rst) begin
            sync_q <= '0;
            press  <= '0;
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-1:0], btn_levels};
            // registered so the pulse is clean for the game logic
            press  <= rise;
        end
    end

endmodule

/* design/mancala_pkg.sv */
package mancala_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // board geometry and counters
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [3:0] place_idx_t;

    // one place or the handful, total never above 60
    typedef logic [5:0] seed_cnt_t;

    localparam int PITS_PER_SIDE = 6;
    localparam int NUM_PLACES    = 14;

    localparam place_idx_t STORE_A = 4'd6;
    localparam place_idx_t STORE_B = 4'd13;

    // flat view of the board, element i is place i
    typedef seed_cnt_t [NUM_PLACES-1:0] place_arr_t;

    // place 0 sits in the low bits so the struct and place_arr_t line up
    typedef struct packed {
        seed_cnt_t store_b;
        seed_cnt_t pit_12;
        seed_cnt_t pit_11;
        seed_cnt_t pit_10;
        seed_cnt_t pit_9;
        seed_cnt_t pit_8;
        seed_cnt_t pit_7;
        seed_cnt_t store_a;
        seed_cnt_t pit_5;
        seed_cnt_t pit_4;
        seed_cnt_t pit_3;
        seed_cnt_t pit_2;
        seed_cnt_t pit_1;
        seed_cnt_t pit_0;
    } board_t;

    ////////////////////////////////////////////////////////////////////////////
    // game encodings
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic {
        PLAYER_A = 1'b0,
        PLAYER_B = 1'b1
    } player_t;

    typedef enum logic [2:0] {
        PH_INIT,
        PH_SELECT,
        PH_SOW,
        PH_SWEEP,
        PH_OVER
    } phase_t;

    typedef enum logic [1:0] {
        RES_NONE,
        RES_A_WINS,
        RES_B_WINS,
        RES_TIE
    } result_t;

    // how the last seed of a move landed
    typedef enum logic [1:0] {
        END_NONE,
        END_STORE,
        END_EMPTY
    } sow_end_t;

    // levels or press pulses
    typedef struct packed {
        logic left;
        logic right;
        logic enter;
    } buttons_t;

    function automatic seed_cnt_t seeds_at(board_t b, place_idx_t idx);
        place_arr_t flat;
        flat = place_arr_t'(b);
        return flat[idx];
    endfunction

    // seeds left in one player's six pockets, stores excluded
    function automatic seed_cnt_t row_total(board_t b, player_t who);
        place_arr_t flat;
        seed_cnt_t  total;
        int         base;
        flat  = place_arr_t'(b);
        total = '0;
        base  = (who == PLAYER_A) ? 0 : int'(STORE_A) + 1;
        for (int i = 0; i < PITS_PER_SIDE; i++) begin
            total = total + flat[base + i];
        end
        return total;
    endfunction

endpackage
